// ==== hmc_pkg.sv ====
package hmc_pkg;

  // --------------------------------------------------------------------------
  // Link and transceiver geometry
  // --------------------------------------------------------------------------
  localparam int NUM_LANES      = 8;                       // Half-width HMC link
  localparam int LANE_WIDTH     = 64;                      // GT fabric word per lane
  localparam int DWIDTH         = NUM_LANES * LANE_WIDTH;  // 512 bit link word
  localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);       // Physical lane number

  // Register file of the link controller
  localparam int RF_AWIDTH      = 5;
  localparam int RF_DWIDTH      = 64;

  // Power-up counter, top bit set after 2**17 locked cycles
  localparam int RST_CNT_WIDTH  = 18;

  typedef logic [DWIDTH-1:0]         link_data_t;  // Lane n in bits 64n+63:64n
  typedef logic [LANE_WIDTH-1:0]     lane_word_t;  // One lane, one clock
  typedef logic [NUM_LANES-1:0]      lane_mask_t;  // One flag per lane
  typedef logic [LANE_IDX_WIDTH-1:0] lane_idx_t;
  typedef logic [RF_AWIDTH-1:0]      rf_addr_t;
  typedef logic [RF_DWIDTH-1:0]      rf_data_t;
  typedef logic [RST_CNT_WIDTH-1:0]  rst_cnt_t;

  // --------------------------------------------------------------------------
  // Register-file access, request from the master and response back
  // --------------------------------------------------------------------------
  typedef struct packed {
    rf_addr_t address;
    logic     read_en;     // Held until access_complete
    logic     write_en;    // Held until access_complete
    rf_data_t write_data;
  } rf_req_t;              // 71 bits

  typedef struct packed {
    rf_data_t read_data;
    logic     invalid_address;
    logic     access_complete;  // Single-cycle end of access
  } rf_rsp_t;                   // 66 bits

  // --------------------------------------------------------------------------
  // Mezzanine sites and their lane wiring
  // --------------------------------------------------------------------------
  typedef logic [1:0] mezz_site_t;
  localparam mezz_site_t DEFAULT_MEZZ_SITE = 2'd2;

  // Entry n holds the physical lane that carries link lane n
  typedef lane_idx_t [NUM_LANES-1:0] lane_map_t;

  // Listed from link lane 7 down to link lane 0
  localparam lane_map_t SITE2_LANE_MAP = {3'd1, 3'd2, 3'd5, 3'd6,  // PHY21 L1/L2, PHY22 L1/L2
                                          3'd0, 3'd3, 3'd4, 3'd7}; // PHY21 L0/L3, PHY22 L0/L3
  localparam lane_map_t SITE3_LANE_MAP = {3'd6, 3'd5, 3'd2, 3'd1,  // PHY12 L1/L2, PHY11 L1/L2
                                          3'd7, 3'd4, 3'd3, 3'd0}; // PHY12 L0/L3, PHY11 L0/L3

  // --------------------------------------------------------------------------
  // Register-file init table, written in index order
  // --------------------------------------------------------------------------
  localparam int INIT_LEN       = 3;
  localparam int INIT_IDX_WIDTH = $clog2(INIT_LEN);

  typedef logic [INIT_IDX_WIDTH-1:0] init_idx_t;

  localparam rf_addr_t INIT_ADDR [INIT_LEN] = '{
    5'd1,  // Token count register
    5'd2,  // Link control
    5'd0   // Init control, last so the link starts with the rest in place
  };

  localparam rf_data_t INIT_DATA [INIT_LEN] = '{
    64'h0000_0000_0000_00FF,  // RX buffer tokens
    64'h0000_0000_0000_0034,  // Scramblers on, lane reversal detect
    64'h0000_0000_0000_0103   // P_RST_N high, init continue
  };

endpackage

// ==== hmc_lane_router.sv ====
`timescale 1ns/100ps

module hmc_lane_router #(
  parameter hmc_pkg::mezz_site_t MEZZ_SITE = hmc_pkg::DEFAULT_MEZZ_SITE
) (
  input  logic                clk_hmc,
  input  logic                SOFT_RESET_IN,
  // Transmit, controller to transceivers
  input  hmc_pkg::link_data_t link_tx_data,   // Link lane order
  output hmc_pkg::link_data_t gt_tx_data,     // Physical lane order
  // Receive, transceivers to controller
  input  hmc_pkg::link_data_t gt_rx_data,     // Physical lane order
  output hmc_pkg::link_data_t link_rx_data,   // Link lane order
  // Bit-slip requests from the controller
  input  hmc_pkg::lane_mask_t link_bit_slip,  // Bit n for link lane n
  output hmc_pkg::lane_mask_t gt_rx_slide     // Bit n for physical lane n
);
  import hmc_pkg::*;

  // --------------------------------------------------------------------------
  // Map selection
  // --------------------------------------------------------------------------
  // Site 3 has its own wiring, the other sites share the site 2 routing
  localparam lane_map_t LANE_MAP = (MEZZ_SITE == 2'd3) ? SITE3_LANE_MAP : SITE2_LANE_MAP;

  link_data_t tx_phys;     // Transmit word in physical order
  link_data_t rx_link;     // Receive word in link order
  lane_mask_t slide_phys;  // Slip flags in physical order

  // One 64 bit lane out of a link word
  function automatic lane_word_t get_lane(input link_data_t word, input lane_idx_t idx);
    get_lane = word[idx*LANE_WIDTH +: LANE_WIDTH];
  endfunction

  // --------------------------------------------------------------------------
  // Lane re-ordering
  // --------------------------------------------------------------------------
  always_comb begin
    tx_phys    = '0;  // Map is a permutation, every lane is overwritten
    rx_link    = '0;
    slide_phys = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      // Physical lane MAP[n] carries link lane n
      tx_phys[LANE_MAP[n]*LANE_WIDTH +: LANE_WIDTH] = get_lane(link_tx_data, lane_idx_t'(n));
      // Link lane n is fed from physical lane MAP[n]
      rx_link[n*LANE_WIDTH +: LANE_WIDTH] = get_lane(gt_rx_data, LANE_MAP[n]);
      // Slip goes to the transceiver that carries the link lane
      slide_phys[LANE_MAP[n]] = link_bit_slip[n];
    end
  end

  // --------------------------------------------------------------------------
  // Output registers, one stage per path
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_hmc or posedge SOFT_RESET_IN) begin
    if (SOFT_RESET_IN) begin
      gt_tx_data   <= '0;
      link_rx_data <= '0;
      gt_rx_slide  <= '0;
    end else begin
      gt_tx_data   <= tx_phys;     // Towards GT TXDATA
      link_rx_data <= rx_link;     // Towards the controller RX
      gt_rx_slide  <= slide_phys;  // Rising edge capture like the data paths
    end
  end

endmodule

// ==== hmc_reset_seq.sv ====
`timescale 1ns/100ps

module hmc_reset_seq (
  input  logic clk_hmc,
  input  logic SOFT_RESET_IN,
  // Clock and transceiver status
  input  logic mmcm_locked,        // Fabric clock manager lock
  input  logic qpll_lock0,         // Quad PLL of the first GT quad
  input  logic qpll_lock1,         // Quad PLL of the second GT quad
  input  logic phy_rx_ready,       // GT receive reset done
  input  logic phy_init_cont_set,  // Controller allows init to go on
  input  logic iic_init_done,      // HMC IIC setup finished
  // Reset and status outputs
  output logic link_res_n,         // Link reset, active low
  output logic hmc_reset_out,      // Same reset, active high
  output logic qpll_lock,          // Both quad PLLs locked
  output logic link_rx_ready       // Gated receive-ready to the controller
);
  import hmc_pkg::*;

  // --------------------------------------------------------------------------
  // Power-up counter
  // --------------------------------------------------------------------------
  rst_cnt_t rst_cnt;  // Locked cycles since reset, saturates at top bit

  // Loss of lock only pauses the count
  always_ff @(posedge clk_hmc or posedge SOFT_RESET_IN) begin
    if (SOFT_RESET_IN) begin
      rst_cnt <= '0;
    end else if (mmcm_locked && !rst_cnt[RST_CNT_WIDTH-1]) begin
      rst_cnt <= rst_cnt + 1'b1;  // Stops once the top bit is set
    end
  end

  // Top bit is the release
  assign link_res_n    = rst_cnt[RST_CNT_WIDTH-1];
  assign hmc_reset_out = ~link_res_n;

  // --------------------------------------------------------------------------
  // Merged status
  // --------------------------------------------------------------------------
  assign qpll_lock = qpll_lock0 & qpll_lock1;  // Board status bit

  // Controller sees RX ready only with the PHY, its own init step and IIC done
  assign link_rx_ready = phy_rx_ready & phy_init_cont_set & iic_init_done;

endmodule

// ==== hmc_rf_init.sv ====
`timescale 1ns/100ps

module hmc_rf_init (
  input  logic             clk_hmc,
  input  logic             SOFT_RESET_IN,
  input  logic             link_res_n,          // Link out of reset
  input  logic             iic_init_done,       // HMC IIC setup finished
  // User register-file port
  input  hmc_pkg::rf_req_t user_rf_req,
  output hmc_pkg::rf_rsp_t user_rf_rsp,
  // Controller register-file port
  output hmc_pkg::rf_req_t ctrl_rf_req,
  input  hmc_pkg::rf_rsp_t ctrl_rf_rsp,
  output logic             open_hmc_init_done   // Table written, user owns the port
);
  import hmc_pkg::*;

  // --------------------------------------------------------------------------
  // Init FSM
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    ST_IDLE,           // Waiting for link reset release and IIC setup
    ST_WRITE,          // First cycle of a table write
    ST_WAIT_COMPLETE,  // Write held until access_complete
    ST_NEXT,           // Enables low for one cycle, step the index
    ST_DONE            // Port handed to the user
  } init_state_t;

  init_state_t state;
  init_state_t state_nxt;
  init_idx_t   idx;          // Current table entry
  logic        last_entry;   // Index on the final entry
  logic        wr_complete;  // Controller ended the write
  rf_req_t     init_req;     // Request from the table

  assign last_entry  = (idx == init_idx_t'(INIT_LEN - 1));
  assign wr_complete = ctrl_rf_rsp.access_complete;

  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE: begin
        if (link_res_n && iic_init_done) begin
          state_nxt = ST_WRITE;
        end
      end
      ST_WRITE, ST_WAIT_COMPLETE: begin
        if (wr_complete) begin
          // Done in the cycle after the last completion
          state_nxt = last_entry ? ST_DONE : ST_NEXT;
        end else begin
          state_nxt = ST_WAIT_COMPLETE;
        end
      end
      ST_NEXT: begin
        state_nxt = ST_WRITE;
      end
      ST_DONE: begin
        state_nxt = ST_DONE;  // Left only by reset
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_hmc or posedge SOFT_RESET_IN) begin
    if (SOFT_RESET_IN) begin
      state <= ST_IDLE;
      idx   <= '0;
    end else begin
      state <= state_nxt;
      if (state == ST_NEXT) begin
        idx <= idx + 1'b1;  // Entry after the completed one
      end
    end
  end

  // --------------------------------------------------------------------------
  // Table request
  // --------------------------------------------------------------------------
  always_comb begin
    init_req            = '0;             // Init side never reads
    init_req.address    = INIT_ADDR[idx];
    init_req.write_data = INIT_DATA[idx];
    init_req.write_en   = (state == ST_WRITE) || (state == ST_WAIT_COMPLETE);
  end

  // --------------------------------------------------------------------------
  // Register-file port mux
  // --------------------------------------------------------------------------
  assign open_hmc_init_done = (state == ST_DONE);

  // Init table first, user port afterwards
  assign ctrl_rf_req = open_hmc_init_done ? user_rf_req : init_req;

  // User sees nothing of the init accesses
  assign user_rf_rsp = open_hmc_init_done ? ctrl_rf_rsp : '0;

endmodule

// ==== hmc_link_shell.sv ====
`timescale 1ns/100ps

module hmc_link_shell #(
  parameter hmc_pkg::mezz_site_t MEZZ_SITE = hmc_pkg::DEFAULT_MEZZ_SITE  // Site 2 or 3
) (
  input  logic                clk_hmc,            // Fabric clock of the link
  input  logic                SOFT_RESET_IN,
  // --------------------------------------------------------------------------
  // Lane data, controller side and transceiver side
  // --------------------------------------------------------------------------
  input  hmc_pkg::link_data_t link_tx_data,
  output hmc_pkg::link_data_t gt_tx_data,
  input  hmc_pkg::link_data_t gt_rx_data,
  output hmc_pkg::link_data_t link_rx_data,
  input  hmc_pkg::lane_mask_t link_bit_slip,
  output hmc_pkg::lane_mask_t gt_rx_slide,
  // --------------------------------------------------------------------------
  // Clock, PHY and IIC status
  // --------------------------------------------------------------------------
  input  logic                mmcm_locked,
  input  logic                qpll_lock0,
  input  logic                qpll_lock1,
  input  logic                phy_rx_ready,
  input  logic                phy_init_cont_set,
  input  logic                iic_init_done,
  output logic                link_res_n,         // Controller reset, active low
  output logic                hmc_reset_out,
  output logic                qpll_lock,
  output logic                link_rx_ready,
  // --------------------------------------------------------------------------
  // Register file, user port and controller port
  // --------------------------------------------------------------------------
  input  hmc_pkg::rf_req_t    user_rf_req,
  output hmc_pkg::rf_rsp_t    user_rf_rsp,
  output hmc_pkg::rf_req_t    ctrl_rf_req,
  input  hmc_pkg::rf_rsp_t    ctrl_rf_rsp,
  output logic                open_hmc_init_done
);
  import hmc_pkg::*;

  // Lane re-ordering for the selected mezzanine site
  hmc_lane_router #(
    .MEZZ_SITE     (MEZZ_SITE)
  ) u_lane_router (
    .clk_hmc       (clk_hmc),
    .SOFT_RESET_IN (SOFT_RESET_IN),
    .link_tx_data  (link_tx_data),
    .gt_tx_data    (gt_tx_data),
    .gt_rx_data    (gt_rx_data),
    .link_rx_data  (link_rx_data),
    .link_bit_slip (link_bit_slip),
    .gt_rx_slide   (gt_rx_slide)
  );

  // Power-up reset and merged status
  hmc_reset_seq u_reset_seq (
    .clk_hmc           (clk_hmc),
    .SOFT_RESET_IN     (SOFT_RESET_IN),
    .mmcm_locked       (mmcm_locked),
    .qpll_lock0        (qpll_lock0),
    .qpll_lock1        (qpll_lock1),
    .phy_rx_ready      (phy_rx_ready),
    .phy_init_cont_set (phy_init_cont_set),
    .iic_init_done     (iic_init_done),
    .link_res_n        (link_res_n),     // Also starts the RF init
    .hmc_reset_out     (hmc_reset_out),
    .qpll_lock         (qpll_lock),
    .link_rx_ready     (link_rx_ready)
  );

  // Register-file init table, then user access
  hmc_rf_init u_rf_init (
    .clk_hmc            (clk_hmc),
    .SOFT_RESET_IN      (SOFT_RESET_IN),
    .link_res_n         (link_res_n),
    .iic_init_done      (iic_init_done),
    .user_rf_req        (user_rf_req),
    .user_rf_rsp        (user_rf_rsp),
    .ctrl_rf_req        (ctrl_rf_req),
    .ctrl_rf_rsp        (ctrl_rf_rsp),
    .open_hmc_init_done (open_hmc_init_done)
  );

endmodule

// ==== tb_hmc_link_shell.sv ====
`timescale 1ns/100ps

module tb_hmc_link_shell;
  import hmc_pkg::*;

  // --------------------------------------------------------------------------
  // Run constants
  // --------------------------------------------------------------------------
  localparam int CLK_PERIOD      = 4;                        // ns
  localparam int RELEASE_CYCLES  = 1 << (RST_CNT_WIDTH - 1);  // Locked cycles to release
  localparam int WATCHDOG_CYCLES = RELEASE_CYCLES + 20000;
  localparam int NUM_WORDS       = 200;                      // Words per routing test
  localparam int SEED            = 32'h019a9a28;

  // Site 2 wiring with entry n the physical lane of link lane n
  localparam int SITE2_MAP [NUM_LANES] = '{7, 4, 3, 0, 6, 5, 2, 1};
  localparam rf_addr_t EXP_INIT_ADDR [INIT_LEN] = '{5'd1, 5'd2, 5'd0};

  logic       clk_hmc;
  logic       SOFT_RESET_IN;
  link_data_t link_tx_data;
  link_data_t gt_tx_data;
  link_data_t gt_rx_data;
  link_data_t link_rx_data;
  lane_mask_t link_bit_slip;
  lane_mask_t gt_rx_slide;
  logic       mmcm_locked;
  logic       qpll_lock0;
  logic       qpll_lock1;
  logic       phy_rx_ready;
  logic       phy_init_cont_set;
  logic       iic_init_done;
  logic       link_res_n;
  logic       hmc_reset_out;
  logic       qpll_lock;
  logic       link_rx_ready;
  rf_req_t    user_rf_req;
  rf_rsp_t    user_rf_rsp;
  rf_req_t    ctrl_rf_req;
  rf_rsp_t    ctrl_rf_rsp;
  logic       open_hmc_init_done;

  int err_count    = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // Register-file emulator state
  rf_data_t emu_mem [32];
  rf_addr_t wr_addr_q [$];  // Writes in arrival order
  rf_data_t wr_data_q [$];
  int       access_count   = 0;
  int       complete_count = 0;

  hmc_link_shell #(
    .MEZZ_SITE (2'd2)
  ) u_dut (
    .clk_hmc            (clk_hmc),
    .SOFT_RESET_IN      (SOFT_RESET_IN),
    .link_tx_data       (link_tx_data),
    .gt_tx_data         (gt_tx_data),
    .gt_rx_data         (gt_rx_data),
    .link_rx_data       (link_rx_data),
    .link_bit_slip      (link_bit_slip),
    .gt_rx_slide        (gt_rx_slide),
    .mmcm_locked        (mmcm_locked),
    .qpll_lock0         (qpll_lock0),
    .qpll_lock1         (qpll_lock1),
    .phy_rx_ready       (phy_rx_ready),
    .phy_init_cont_set  (phy_init_cont_set),
    .iic_init_done      (iic_init_done),
    .link_res_n         (link_res_n),
    .hmc_reset_out      (hmc_reset_out),
    .qpll_lock          (qpll_lock),
    .link_rx_ready      (link_rx_ready),
    .user_rf_req        (user_rf_req),
    .user_rf_rsp        (user_rf_rsp),
    .ctrl_rf_req        (ctrl_rf_req),
    .ctrl_rf_rsp        (ctrl_rf_rsp),
    .open_hmc_init_done (open_hmc_init_done)
  );

  initial begin : clock_gen
    clk_hmc = 1'b0;
    forever #(CLK_PERIOD / 2) clk_hmc = ~clk_hmc;
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Regression failed");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Controller register file that samples on the rising edge and answers on the falling edge
  // --------------------------------------------------------------------------
  initial begin : rf_emulator
    rf_req_t req;
    int      delay;
    ctrl_rf_rsp = '0;
    for (int a = 0; a < 32; a++) begin
      emu_mem[a] = {32'hFEED_0000 + 32'(a), 32'(a) * 32'h0101_0101};  // Per-address fill
    end
    forever begin
      @(posedge clk_hmc);
      if (!SOFT_RESET_IN && (ctrl_rf_req.read_en || ctrl_rf_req.write_en)) begin
        req   = ctrl_rf_req;
        delay = 1 + int'($urandom % 4);  // 1 to 4 cycles
        access_count++;
        repeat (delay - 1) @(posedge clk_hmc);
        @(negedge clk_hmc);
        ctrl_rf_rsp = '0;
        if (req.address > 5'd15) begin
          ctrl_rf_rsp.invalid_address = 1'b1;  // Upper half unmapped
        end else if (req.write_en) begin
          emu_mem[req.address] = req.write_data;
        end else begin
          ctrl_rf_rsp.read_data = emu_mem[req.address];
        end
        if (req.write_en) begin
          wr_addr_q.push_back(req.address);
          wr_data_q.push_back(req.write_data);
        end
        ctrl_rf_rsp.access_complete = 1'b1;
        complete_count++;
        @(negedge clk_hmc);
        ctrl_rf_rsp = '0;  // Single-cycle complete while the master drops its enable
      end
    end
  end

  // --------------------------------------------------------------------------
  // Reporting and reference helpers
  // --------------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [DWIDTH-1:0] exp,
                                 input logic [DWIDTH-1:0] act);
    err_count++;
    $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
  endtask

  task automatic report_failure(input string name, input string what);
    err_count++;
    $display("ERROR %s: %s", name, what);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (err_count == errs_before) begin
      $display("%s: PASS", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL, %0d errors", name, err_count - errs_before);
    end
  endtask

  function automatic link_data_t rand_link_word();
    link_data_t w;
    for (int i = 0; i < DWIDTH / 32; i++) begin
      w[i*32 +: 32] = $urandom;
    end
    return w;
  endfunction

  // Physical lane MAP[n] carries link lane n
  function automatic link_data_t expect_tx(input link_data_t word);
    link_data_t phys;
    phys = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      phys[SITE2_MAP[n]*LANE_WIDTH +: LANE_WIDTH] = word[n*LANE_WIDTH +: LANE_WIDTH];
    end
    return phys;
  endfunction

  function automatic link_data_t expect_rx(input link_data_t phys);
    link_data_t word;
    word = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      word[n*LANE_WIDTH +: LANE_WIDTH] = phys[SITE2_MAP[n]*LANE_WIDTH +: LANE_WIDTH];
    end
    return word;
  endfunction

  function automatic lane_mask_t expect_slide(input lane_mask_t slip);
    lane_mask_t phys;
    phys = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      phys[SITE2_MAP[n]] = slip[n];
    end
    return phys;
  endfunction

  // One user access held until access_complete or max_cycles
  task automatic rf_user_access(input logic wr, input rf_addr_t addr, input rf_data_t wdata,
                                input int max_cycles, output rf_rsp_t rsp, output logic ok);
    int cycles;
    ok  = 1'b0;
    rsp = '0;
    @(negedge clk_hmc);
    user_rf_req            = '0;
    user_rf_req.address    = addr;
    user_rf_req.write_en   = wr;
    user_rf_req.read_en    = !wr;
    user_rf_req.write_data = wdata;
    for (cycles = 0; cycles < max_cycles && !ok; cycles++) begin
      @(posedge clk_hmc);
      if (user_rf_rsp.access_complete) begin
        ok  = 1'b1;
        rsp = user_rf_rsp;
      end
    end
    @(negedge clk_hmc);
    user_rf_req = '0;  // Enable low in the cycle after complete
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_state();
    int   errs_before;
    logic q0;
    logic q1;
    logic rdy;
    logic cont;
    logic iic;
    errs_before = err_count;
    for (int i = 0; i < 3 + 8; i++) begin
      if (i == 3) begin
        @(negedge clk_hmc);
        SOFT_RESET_IN = 1'b0;  // Released after 3 cycles
      end
      if (i >= 3) begin
        @(negedge clk_hmc);
        q0   = 1'($urandom);
        q1   = 1'($urandom);
        rdy  = 1'($urandom);
        cont = 1'($urandom);
        iic  = 1'($urandom);
        qpll_lock0        = q0;
        qpll_lock1        = q1;
        phy_rx_ready      = rdy;
        phy_init_cont_set = cont;
        iic_init_done     = iic;
      end
      @(posedge clk_hmc);
      if (link_res_n !== 1'b0) report_mismatch("reset_state", '0, DWIDTH'(link_res_n));
      if (open_hmc_init_done !== 1'b0) begin
        report_mismatch("reset_state", '0, DWIDTH'(open_hmc_init_done));
      end
      if (ctrl_rf_req.read_en || ctrl_rf_req.write_en) begin
        report_failure("reset_state", "register-file enable high while in reset");
      end
      if (i >= 3 && qpll_lock !== (q0 & q1)) begin
        report_mismatch("reset_state", DWIDTH'(q0 & q1), DWIDTH'(qpll_lock));
      end
      if (i >= 3 && link_rx_ready !== (rdy & cont & iic)) begin
        report_mismatch("reset_state", DWIDTH'(rdy & cont & iic), DWIDTH'(link_rx_ready));
      end
    end
    @(negedge clk_hmc);
    iic_init_done = 1'b0;  // Init must wait for its own test
    finish_test("reset_state", errs_before);
  endtask

  task automatic test_tx_routing();
    int         errs_before;
    link_data_t prev;
    errs_before = err_count;
    prev        = '0;
    for (int i = 0; i <= NUM_WORDS; i++) begin
      @(negedge clk_hmc);
      link_tx_data = rand_link_word();
      @(posedge clk_hmc);
      if (i > 0 && gt_tx_data !== expect_tx(prev)) begin  // Word from one cycle back
        report_mismatch("tx_routing", expect_tx(prev), gt_tx_data);
      end
      prev = link_tx_data;
    end
    finish_test("tx_routing", errs_before);
  endtask

  task automatic test_rx_slip_routing();
    int         errs_before;
    link_data_t prev_rx;
    lane_mask_t prev_slip;
    errs_before = err_count;
    prev_rx     = '0;
    prev_slip   = '0;
    for (int i = 0; i <= NUM_WORDS; i++) begin
      @(negedge clk_hmc);
      gt_rx_data    = rand_link_word();
      link_bit_slip = 8'($urandom);
      @(posedge clk_hmc);
      if (i > 0 && link_rx_data !== expect_rx(prev_rx)) begin
        report_mismatch("rx_slip_routing", expect_rx(prev_rx), link_rx_data);
      end
      if (i > 0 && gt_rx_slide !== expect_slide(prev_slip)) begin
        report_mismatch("rx_slip_routing", DWIDTH'(expect_slide(prev_slip)),
                        DWIDTH'(gt_rx_slide));
      end
      prev_rx   = gt_rx_data;
      prev_slip = link_bit_slip;
    end
    finish_test("rx_slip_routing", errs_before);
  endtask

  task automatic test_lock_release();
    int   errs_before;
    int   cyc;
    int   locked_cnt;
    int   drop_start;
    int   drop_len;
    logic exp_rel;
    errs_before = err_count;
    cyc         = 0;
    locked_cnt  = 0;
    drop_start  = 100 + int'($urandom % 1000);
    drop_len    = 1 + int'($urandom % 200);
    while (locked_cnt < RELEASE_CYCLES + 4 && err_count - errs_before < 5) begin
      @(negedge clk_hmc);
      mmcm_locked = !(cyc >= drop_start && cyc < drop_start + drop_len);  // Lock gap
      @(posedge clk_hmc);
      exp_rel = (locked_cnt >= RELEASE_CYCLES);  // Locked edges seen so far
      if (link_res_n !== exp_rel) begin
        report_mismatch("lock_release", DWIDTH'(exp_rel), DWIDTH'(link_res_n));
      end
      if (hmc_reset_out !== !exp_rel) begin
        report_mismatch("lock_release", DWIDTH'(!exp_rel), DWIDTH'(hmc_reset_out));
      end
      if (mmcm_locked) locked_cnt++;
      cyc++;
    end
    finish_test("lock_release", errs_before);
  endtask

  task automatic test_user_blocked();
    int      errs_before;
    int      base;
    rf_rsp_t rsp;
    logic    ok;
    errs_before = err_count;
    base        = access_count;
    rf_user_access(1'b0, 5'd3, '0, 20, rsp, ok);
    if (ok) report_failure("user_blocked", "user read completed before init done");
    if (access_count != base) report_failure("user_blocked", "user read reached the emulator");
    finish_test("user_blocked", errs_before);
  endtask

  task automatic test_rf_init();
    int   errs_before;
    int   base_acc;
    int   base_cpl;
    int   base_wr;
    logic done_seen;
    errs_before = err_count;
    base_acc    = access_count;
    base_cpl    = complete_count;
    base_wr     = wr_addr_q.size();
    done_seen   = 1'b0;
    repeat (5 + int'($urandom % 40)) begin  // IIC setup still running
      @(posedge clk_hmc);
      if (ctrl_rf_req.read_en || ctrl_rf_req.write_en) begin
        report_failure("rf_init", "register-file access before IIC setup done");
      end
    end
    @(negedge clk_hmc);
    iic_init_done = 1'b1;
    for (int c = 0; c < 200 && !done_seen; c++) begin
      @(posedge clk_hmc);
      if (!open_hmc_init_done && user_rf_rsp !== '0) begin  // Init responses stay hidden
        report_mismatch("rf_init", '0, DWIDTH'(user_rf_rsp));
      end
      if (open_hmc_init_done) begin
        done_seen = 1'b1;
        if (complete_count - base_cpl < INIT_LEN) begin
          report_failure("rf_init", "init done raised before the last write completed");
        end
      end
    end
    if (!done_seen) report_failure("rf_init", "init done never rose");
    if (access_count - base_acc != INIT_LEN || wr_addr_q.size() - base_wr != INIT_LEN) begin
      report_failure("rf_init", "wrong number of init accesses");
    end else begin
      for (int i = 0; i < INIT_LEN; i++) begin
        if (wr_addr_q[base_wr+i] !== EXP_INIT_ADDR[i]) begin
          report_mismatch("rf_init", DWIDTH'(EXP_INIT_ADDR[i]), DWIDTH'(wr_addr_q[base_wr+i]));
        end
        if (wr_data_q[base_wr+i] !== INIT_DATA[i]) begin
          report_mismatch("rf_init", DWIDTH'(INIT_DATA[i]), DWIDTH'(wr_data_q[base_wr+i]));
        end
      end
    end
    finish_test("rf_init", errs_before);
  endtask

  task automatic test_user_access();
    int       errs_before;
    int       base;
    rf_addr_t addr [3];
    rf_data_t data [3];
    rf_rsp_t  rsp;
    logic     ok;
    errs_before = err_count;
    base        = access_count;
    addr        = '{5'd3, 5'd9, 5'd15};
    for (int i = 0; i < 3; i++) begin
      data[i] = {$urandom, $urandom};
      rf_user_access(1'b1, addr[i], data[i], 50, rsp, ok);
      if (!ok) report_failure("user_access", "user write got no access_complete");
    end
    for (int i = 0; i < 3; i++) begin
      rf_user_access(1'b0, addr[i], '0, 50, rsp, ok);
      if (!ok) begin
        report_failure("user_access", "user read got no access_complete");
      end else if (rsp.read_data !== data[i]) begin
        report_mismatch("user_access", DWIDTH'(data[i]), DWIDTH'(rsp.read_data));
      end
    end
    rf_user_access(1'b0, 5'd20, '0, 50, rsp, ok);  // Unmapped address
    if (!ok) begin
      report_failure("user_access", "read of address 20 got no access_complete");
    end else if (rsp.invalid_address !== 1'b1) begin
      report_mismatch("user_access", DWIDTH'(1'b1), DWIDTH'(rsp.invalid_address));
    end
    if (access_count - base != 7) report_failure("user_access", "emulator missed user accesses");
    finish_test("user_access", errs_before);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : main
    void'($urandom(SEED));
    SOFT_RESET_IN     = 1'b1;
    link_tx_data      = '0;
    gt_rx_data        = '0;
    link_bit_slip     = '0;
    mmcm_locked       = 1'b0;  // Counter held until the lock test
    qpll_lock0        = 1'b0;
    qpll_lock1        = 1'b0;
    phy_rx_ready      = 1'b0;
    phy_init_cont_set = 1'b0;
    iic_init_done     = 1'b0;
    user_rf_req       = '0;
    test_reset_state();
    test_tx_routing();
    test_rx_slip_routing();
    test_lock_release();
    test_user_blocked();
    test_rf_init();
    test_user_access();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
hmc_pkg.sv
hmc_lane_router.sv
hmc_reset_seq.sv
hmc_rf_init.sv
hmc_link_shell.sv
tb_hmc_link_shell.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and decide on the pass message in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_hmc_link_shell -f all.f -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 &&
grep -q "Regression passed" sim.log &&
echo "Simulation PASS" ||
{ echo "Simulation FAIL, see build.log and sim.log"; exit 1; }
